// File: Bender.yml
package:
  name: cpu16

sources:
  - design/cpu_pkg.sv
  - design/phase_timer.sv
  - design/controller.sv
  - design/alu.sv
  - design/reg_file.sv
  - design/datapath.sv
  - design/cpu_top.sv
  - target: test
    files:
      - test/tb_cpu.sv

// File: design/alu.sv
module alu
        import cpu_pkg::*;
(
        input  word_t     a,
        input  word_t     b,
        input  logic      carry_in,
        input  alu_func_t func,
        output word_t     result,
        output flags_t    flags
);

        localparam int msb = data_width - 1;

        logic [data_width:0]     sum;
        logic [data_width:0]     diff;
        logic [2*data_width-1:0] rol_w;
        logic [2*data_width-1:0] ror_w;
        logic [3:0]              cnt;

        assign cnt   = b[3:0];
        assign sum   = {1'b0, a} + {1'b0, b} + carry_in;
        assign diff  = {1'b0, a} - {1'b0, b} - carry_in; // top bit is the borrow
        assign rol_w = {a, a} << cnt;
        assign ror_w = {a, a} >> cnt;

        always_comb begin
                result = '0;
                flags.c = 1'b0;
                flags.v = 1'b0;
                case (func)
                alu_add: begin
                        result = sum[msb:0];
                        flags.c = sum[data_width];
                        flags.v = (a[msb] == b[msb]) && (result[msb] != a[msb]);
                end
                alu_sub: begin
                        result = diff[msb:0];
                        flags.c = diff[data_width];
                        flags.v = (a[msb] != b[msb]) && (result[msb] != a[msb]);
                end
                alu_and: result = a & b;
                alu_or:  result = a | b;
                alu_xor: result = a ^ b;
                alu_not: result = ~a;
                alu_shl: result = a << cnt;
                alu_shr: result = a >> cnt;
                alu_rol: result = rol_w[2*data_width-1:data_width];
                alu_ror: result = ror_w[msb:0];
                alu_sar: result = $signed(a) >>> cnt;
                default: result = a;
                endcase
                flags.z = (result == '0);
                flags.s = result[msb];
        end

endmodule

// File: design/controller.sv
module controller
        import cpu_pkg::*;
(
        input  phase_t phase,
        input  word_t  instr,
        input  flags_t flags,
        output ctrl_t  ctrl
);

        // ar <= pc, pc <= pc + 1
        localparam ctrl_t step_pc = '{
                alu_func: alu_add, carry_sel: cin_one, a_sel: a_pc, b_sel: b_zero,
                reg_we: 1'b0, pc_we: 1'b1, ar_sel: ar_pc, ar_we: 1'b1, ir_we: 1'b0,
                flag_op: fl_keep, mem_wr: 1'b0};

        logic [7:0] opcode;
        logic       taken;

        assign opcode = instr[15:8];

        always_comb begin
                case (opcode)
                op_jr:   taken = 1'b1;
                op_jrs:  taken = flags.s;
                op_jrns: taken = !flags.s;
                op_jrc:  taken = flags.c;
                op_jrnc: taken = !flags.c;
                op_jrz:  taken = flags.z;
                op_jrnz: taken = !flags.z;
                default: taken = 1'b0;
                endcase
        end

        always_comb begin
                ctrl = '0; // idle word
                case (phase)
                ph_fetch_addr: ctrl = step_pc;
                ph_fetch_ir:   ctrl.ir_we = 1'b1;
                ph_exec: begin
                        case (opcode)
                        op_add, op_sub, op_and, op_cmp, op_xor, op_test, op_or, op_mvrr,
                        op_dec, op_inc, op_shl, op_shr, op_adc, op_sbb, op_not, op_rol,
                        op_ror, op_sar: begin
                                ctrl.a_sel = a_dst;
                                ctrl.b_sel = b_src;
                                ctrl.reg_we = !(opcode inside {op_cmp, op_test});
                                ctrl.flag_op = (opcode == op_mvrr) ? fl_keep : fl_update;
                                case (opcode)
                                op_sub, op_cmp:  ctrl.alu_func = alu_sub;
                                op_and, op_test: ctrl.alu_func = alu_and;
                                op_xor:          ctrl.alu_func = alu_xor;
                                op_or:           ctrl.alu_func = alu_or;
                                op_mvrr: begin
                                        ctrl.alu_func = alu_or; // 0 | src
                                        ctrl.a_sel = a_zero;
                                end
                                op_dec: begin
                                        ctrl.alu_func = alu_sub;
                                        ctrl.b_sel = b_zero;
                                        ctrl.carry_sel = cin_one;
                                end
                                op_inc: begin
                                        ctrl.alu_func = alu_add;
                                        ctrl.b_sel = b_zero;
                                        ctrl.carry_sel = cin_one;
                                end
                                op_adc: begin
                                        ctrl.alu_func = alu_add;
                                        ctrl.carry_sel = cin_flag;
                                end
                                op_sbb: begin
                                        ctrl.alu_func = alu_sub;
                                        ctrl.carry_sel = cin_flag;
                                end
                                op_not: ctrl.alu_func = alu_not;
                                op_shl: ctrl.alu_func = alu_shl;
                                op_shr: ctrl.alu_func = alu_shr;
                                op_rol: ctrl.alu_func = alu_rol;
                                op_ror: ctrl.alu_func = alu_ror;
                                op_sar: ctrl.alu_func = alu_sar;
                                default: ctrl.alu_func = alu_add;
                                endcase
                        end
                        op_jr, op_jrs, op_jrns, op_jrc, op_jrnc, op_jrz, op_jrnz: begin
                                ctrl.a_sel = a_pc; // pc already past the jump
                                ctrl.b_sel = b_off;
                                ctrl.pc_we = taken;
                        end
                        op_clc: ctrl.flag_op = fl_clc;
                        op_stc: ctrl.flag_op = fl_stc;
                        default: ;
                        endcase
                end
                ph_mem1: begin
                        case (opcode)
                        op_jmpa, op_mvrd: ctrl = step_pc; // operand word
                        op_ldrr: begin
                                ctrl.ar_sel = ar_src;
                                ctrl.ar_we = 1'b1;
                        end
                        op_strr: begin
                                ctrl.alu_func = alu_or; // pass dest register
                                ctrl.a_sel = a_dst;
                                ctrl.b_sel = b_zero;
                                ctrl.ar_sel = ar_result;
                                ctrl.ar_we = 1'b1;
                        end
                        default: ;
                        endcase
                end
                ph_mem2: begin
                        ctrl.alu_func = alu_or;
                        ctrl.a_sel = a_zero;
                        ctrl.b_sel = b_mem;
                        case (opcode)
                        op_jmpa:          ctrl.pc_we = 1'b1;
                        op_mvrd, op_ldrr: ctrl.reg_we = 1'b1;
                        op_strr:          ctrl.mem_wr = 1'b1;
                        default: ;
                        endcase
                end
                default: ;
                endcase
        end

        // phase moves every cycle, so this samples each settled word
        a_one_target: assert property (@(phase) !(ctrl.reg_we && ctrl.pc_we));

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

        localparam int data_width = 16;
        localparam int reg_count  = 16;

        typedef logic [data_width-1:0] word_t;
        typedef logic [3:0]            reg_idx_t;

        typedef enum logic [2:0] {
                ph_reset      = 3'b100,
                ph_fetch_addr = 3'b000,
                ph_fetch_ir   = 3'b001,
                ph_exec       = 3'b011,
                ph_mem1       = 3'b101,
                ph_mem2       = 3'b111
        } phase_t;

        // alu group
        localparam logic [7:0] op_add  = 8'h00;
        localparam logic [7:0] op_sub  = 8'h01;
        localparam logic [7:0] op_and  = 8'h02;
        localparam logic [7:0] op_cmp  = 8'h03;
        localparam logic [7:0] op_xor  = 8'h04;
        localparam logic [7:0] op_test = 8'h05;
        localparam logic [7:0] op_or   = 8'h06;
        localparam logic [7:0] op_mvrr = 8'h07;
        localparam logic [7:0] op_dec  = 8'h08;
        localparam logic [7:0] op_inc  = 8'h09;
        localparam logic [7:0] op_shl  = 8'h0A;
        localparam logic [7:0] op_shr  = 8'h0B;
        localparam logic [7:0] op_adc  = 8'h0C;
        localparam logic [7:0] op_sbb  = 8'h0D;
        localparam logic [7:0] op_not  = 8'h0E;
        localparam logic [7:0] op_rol  = 8'h11;
        localparam logic [7:0] op_ror  = 8'h12;
        localparam logic [7:0] op_sar  = 8'h13;
        // relative jumps
        localparam logic [7:0] op_jr   = 8'h40;
        localparam logic [7:0] op_jrs  = 8'h41;
        localparam logic [7:0] op_jrns = 8'h43;
        localparam logic [7:0] op_jrc  = 8'h44;
        localparam logic [7:0] op_jrnc = 8'h45;
        localparam logic [7:0] op_jrz  = 8'h46;
        localparam logic [7:0] op_jrnz = 8'h47;
        localparam logic [7:0] op_clc  = 8'h78;
        localparam logic [7:0] op_stc  = 8'h7A;
        // memory class, top bit set
        localparam logic [7:0] op_jmpa = 8'h80;
        localparam logic [7:0] op_mvrd = 8'h81;
        localparam logic [7:0] op_ldrr = 8'h82;
        localparam logic [7:0] op_strr = 8'h83;

        typedef enum logic [3:0] {
                alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_not,
                alu_shl, alu_shr, alu_rol, alu_ror, alu_sar
        } alu_func_t;

        typedef enum logic [1:0] {cin_zero, cin_one, cin_flag} carry_sel_t;
        typedef enum logic [1:0] {a_dst, a_pc, a_zero} a_sel_t;
        typedef enum logic [1:0] {b_src, b_mem, b_off, b_zero} b_sel_t;
        typedef enum logic [1:0] {ar_pc, ar_result, ar_src} ar_sel_t;
        typedef enum logic [1:0] {fl_keep, fl_update, fl_clc, fl_stc} flag_op_t;

        typedef struct packed {
                logic c;
                logic z;
                logic v;
                logic s;
        } flags_t;

        typedef struct packed {
                alu_func_t  alu_func;
                carry_sel_t carry_sel;
                a_sel_t     a_sel;
                b_sel_t     b_sel;
                logic       reg_we;
                logic       pc_we;
                ar_sel_t    ar_sel;
                logic       ar_we;
                logic       ir_we;
                flag_op_t   flag_op;
                logic       mem_wr;
        } ctrl_t;

endpackage

// File: design/cpu_top.sv
module cpu_top
        import cpu_pkg::*;
(
        input  logic  clk,
        input  logic  reset,
        input  word_t mem_rdata,
        output word_t mem_addr,
        output word_t mem_wdata,
        output logic  mem_wr
);

        phase_t phase;
        word_t  instr;
        flags_t flags;
        ctrl_t  ctrl;

        phase_timer u_timer (
                .clk   (clk),
                .reset (reset),
                .instr (instr),
                .phase (phase)
        );

        controller u_ctrl (
                .phase (phase),
                .instr (instr),
                .flags (flags),
                .ctrl  (ctrl)
        );

        datapath u_dp (
                .clk       (clk),
                .reset     (reset),
                .ctrl      (ctrl),
                .mem_rdata (mem_rdata),
                .instr     (instr),
                .flags     (flags),
                .mem_addr  (mem_addr),
                .mem_wdata (mem_wdata),
                .mem_wr    (mem_wr)
        );

endmodule

// File: design/datapath.sv
module datapath
        import cpu_pkg::*;
(
        input  logic   clk,
        input  logic   reset,
        input  ctrl_t  ctrl,
        input  word_t  mem_rdata,
        output word_t  instr,
        output flags_t flags,
        output word_t  mem_addr,
        output word_t  mem_wdata,
        output logic   mem_wr
);

        word_t  pc;
        word_t  ar;
        word_t  ir;
        flags_t flag_reg;
        word_t  reg_a;
        word_t  reg_b;
        word_t  a_op;
        word_t  b_op;
        word_t  result;
        flags_t alu_flags;
        logic   carry_in;

        reg_file u_regs (
                .clk    (clk),
                .reset  (reset),
                .rd_a   (ir[7:4]), // destination
                .rd_b   (ir[3:0]), // source
                .wr_idx (ir[7:4]),
                .we     (ctrl.reg_we),
                .wdata  (result),
                .a      (reg_a),
                .b      (reg_b)
        );

        alu u_alu (
                .a        (a_op),
                .b        (b_op),
                .carry_in (carry_in),
                .func     (ctrl.alu_func),
                .result   (result),
                .flags    (alu_flags)
        );

        always_comb begin
                case (ctrl.a_sel)
                a_dst:   a_op = reg_a;
                a_pc:    a_op = pc;
                default: a_op = '0;
                endcase
                case (ctrl.b_sel)
                b_src:   b_op = reg_b;
                b_mem:   b_op = mem_rdata;
                b_off:   b_op = {{8{ir[7]}}, ir[7:0]}; // signed jump offset
                default: b_op = '0;
                endcase
                case (ctrl.carry_sel)
                cin_one:  carry_in = 1'b1;
                cin_flag: carry_in = flag_reg.c;
                default:  carry_in = 1'b0;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        pc <= '0;
                        ar <= '0;
                        ir <= '0;
                        flag_reg <= '0;
                end else begin
                        if (ctrl.pc_we)
                                pc <= result;
                        if (ctrl.ar_we) begin
                                case (ctrl.ar_sel)
                                ar_pc:     ar <= pc;
                                ar_result: ar <= result;
                                default:   ar <= reg_b;
                                endcase
                        end
                        if (ctrl.ir_we)
                                ir <= mem_rdata;
                        case (ctrl.flag_op)
                        fl_update: flag_reg <= alu_flags;
                        fl_clc:    flag_reg.c <= 1'b0;
                        fl_stc:    flag_reg.c <= 1'b1;
                        default: ;
                        endcase
                end
        end

        assign instr     = ir;
        assign flags     = flag_reg;
        assign mem_addr  = ar;
        assign mem_wdata = reg_b;
        assign mem_wr    = ctrl.mem_wr;

        a_wr_excl: assert property (@(posedge clk) disable iff (reset)
                !(mem_wr && ctrl.reg_we));

endmodule

// File: design/phase_timer.sv
module phase_timer
        import cpu_pkg::*;
(
        input  logic   clk,
        input  logic   reset,
        input  word_t  instr,
        output phase_t phase
);

        always_ff @(posedge clk) begin
                if (reset) begin
                        phase <= ph_reset;
                end else begin
                        case (phase)
                        ph_reset:      phase <= ph_fetch_addr;
                        ph_fetch_addr: phase <= ph_fetch_ir;
                        ph_fetch_ir:   phase <= ph_exec;
                        ph_exec:       phase <= instr[15] ? ph_mem1 : ph_fetch_addr; // memory class
                        ph_mem1:       phase <= ph_mem2;
                        ph_mem2:       phase <= ph_fetch_addr;
                        default:       phase <= ph_reset;
                        endcase
                end
        end

        a_phase_legal: assert property (@(posedge clk) disable iff (reset)
                phase inside {ph_reset, ph_fetch_addr, ph_fetch_ir, ph_exec, ph_mem1, ph_mem2});

endmodule

// File: design/reg_file.sv
module reg_file
        import cpu_pkg::*;
(
        input  logic     clk,
        input  logic     reset,
        input  reg_idx_t rd_a,
        input  reg_idx_t rd_b,
        input  reg_idx_t wr_idx,
        input  logic     we,
        input  word_t    wdata,
        output word_t    a,
        output word_t    b
);

        word_t regs [reg_count];

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < reg_count; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we) begin
                        regs[wr_idx] <= wdata;
                end
        end

        assign a = regs[rd_a];
        assign b = regs[rd_b];

endmodule

// File: files.f
design/cpu_pkg.sv
design/phase_timer.sv
design/controller.sv
design/alu.sv
design/reg_file.sv
design/datapath.sv
design/cpu_top.sv
test/tb_cpu.sv

// File: test/tb_cpu.sv
module tb_cpu
        import cpu_pkg::*;
();

        timeunit 1ns;
        timeprecision 1ps;

        localparam int mem_words = 256;

        logic   clk;
        logic   reset;
        word_t  mem_rdata;
        word_t  mem_addr;
        word_t  mem_wdata;
        logic   mem_wr;

        word_t  mem [mem_words];
        word_t  prog [$];
        word_t  m_mem [mem_words]; // reference model state
        word_t  m_reg [reg_count];
        word_t  m_pc;
        flags_t m_flags;

        logic [7:0] alu_ops [18] = '{op_add, op_sub, op_and, op_cmp, op_xor, op_test, op_or,
                op_mvrr, op_dec, op_inc, op_shl, op_shr, op_adc, op_sbb, op_not, op_rol,
                op_ror, op_sar};
        logic [7:0] cond_jumps [6] = '{op_jrs, op_jrns, op_jrc, op_jrnc, op_jrz, op_jrnz};

        int seed = 32'h630c_c1ba;
        int errors = 0;
        int checks = 0;
        int tests = 0;
        int tests_failed = 0;
        int n_writes = 0;
        int cycles = 0;
        int cycle_limit = 200;

        cpu_top uut (
                .clk       (clk),
                .reset     (reset),
                .mem_rdata (mem_rdata),
                .mem_addr  (mem_addr),
                .mem_wdata (mem_wdata),
                .mem_wr    (mem_wr)
        );

        assign mem_rdata = mem[mem_addr[7:0]]; // combinational read

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        always @(posedge clk) begin
                if (mem_wr) begin
                        mem[mem_addr[7:0]] <= mem_wdata;
                        n_writes++;
                end
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles > cycle_limit) begin
                        $display("timeout: program did not reach its end within %0d cycles",
                                cycle_limit);
                        $display("sim failed");
                        $finish;
                end
        end

        function automatic int pick(int n);
                return $unsigned($random(seed)) % n;
        endfunction

        function automatic word_t rnd_word();
                return 16'($random(seed));
        endfunction

        function automatic logic [7:0] pair(int dst, int src);
                return {4'(dst), 4'(src)};
        endfunction

        function automatic void put(logic [7:0] op, logic [7:0] operand);
                prog.push_back({op, operand});
        endfunction

        function automatic void load_reg(int r, word_t value);
                put(op_mvrd, pair(r, 0));
                prog.push_back(value);
        endfunction

        // undefined opcode, short or memory class
        function automatic void put_filler();
                if (pick(2) == 0)
                        put(8'h20 | 8'(pick(32)), 8'(pick(256)));
                else
                        put(8'hA0 | 8'(pick(32)), 8'(pick(256)));
        endfunction

        task automatic compare_value(string name, word_t expected, word_t actual);
                checks++;
                if (expected !== actual) begin
                        errors++;
                        $display("mismatch at %0t: %s expected %h actual %h", $time, name,
                                expected, actual);
                end
        endtask

        // {carry or borrow, signed overflow, result} from integer arithmetic
        function automatic logic [17:0] arith(word_t x, word_t y, logic cin, logic subtract);
                int us;
                int ss;

                if (subtract) begin
                        us = int'(x) - int'(y) - int'(cin);
                        ss = int'($signed(x)) - int'($signed(y)) - int'(cin);
                end else begin
                        us = int'(x) + int'(y) + int'(cin);
                        ss = int'($signed(x)) + int'($signed(y)) + int'(cin);
                end
                return {(us < 0 || us > 65535), (ss < -32768 || ss > 32767), us[15:0]};
        endfunction

        // runs one instruction on the model
        task automatic model_step(output int len, output logic st, output word_t st_addr,
                        output word_t st_data);
                word_t      ins;
                word_t      d;
                word_t      s;
                word_t      r;
                word_t      off;
                logic [7:0] op;
                logic       cf;
                logic       vf;
                logic       alu;

                ins = m_mem[m_pc[7:0]];
                op = ins[15:8];
                d = m_reg[ins[7:4]];
                s = m_reg[ins[3:0]];
                off = {{8{ins[7]}}, ins[7:0]};
                alu = (op <= 8'h13) && (op != 8'h0F) && (op != 8'h10);
                len = op[7] ? 5 : 3;
                st = 1'b0;
                st_addr = '0;
                st_data = '0;
                cf = 1'b0;
                vf = 1'b0;
                r = '0;
                m_pc = m_pc + 16'd1;
                case (op)
                op_add:          {cf, vf, r} = arith(d, s, 1'b0, 1'b0);
                op_adc:          {cf, vf, r} = arith(d, s, m_flags.c, 1'b0);
                op_inc:          {cf, vf, r} = arith(d, 16'd1, 1'b0, 1'b0);
                op_sub, op_cmp:  {cf, vf, r} = arith(d, s, 1'b0, 1'b1);
                op_sbb:          {cf, vf, r} = arith(d, s, m_flags.c, 1'b1);
                op_dec:          {cf, vf, r} = arith(d, 16'd1, 1'b0, 1'b1);
                op_and, op_test: r = d & s;
                op_or:           r = d | s;
                op_xor:          r = d ^ s;
                op_not:          r = ~d;
                op_mvrr:         r = s;
                op_shl:          r = d << s[3:0];
                op_shr:          r = d >> s[3:0];
                op_sar:          r = $signed(d) >>> s[3:0];
                op_rol:          r = (d << s[3:0]) | (d >> (5'd16 - s[3:0]));
                op_ror:          r = (d >> s[3:0]) | (d << (5'd16 - s[3:0]));
                op_jr:           m_pc = m_pc + off;
                op_jrs:          if (m_flags.s) m_pc = m_pc + off;
                op_jrns:         if (!m_flags.s) m_pc = m_pc + off;
                op_jrc:          if (m_flags.c) m_pc = m_pc + off;
                op_jrnc:         if (!m_flags.c) m_pc = m_pc + off;
                op_jrz:          if (m_flags.z) m_pc = m_pc + off;
                op_jrnz:         if (!m_flags.z) m_pc = m_pc + off;
                op_clc:          m_flags.c = 1'b0;
                op_stc:          m_flags.c = 1'b1;
                op_jmpa:         m_pc = m_mem[m_pc[7:0]];
                op_mvrd: begin
                        m_reg[ins[7:4]] = m_mem[m_pc[7:0]];
                        m_pc = m_pc + 16'd1;
                end
                op_ldrr:         m_reg[ins[7:4]] = m_mem[s[7:0]];
                op_strr: begin
                        st = 1'b1;
                        st_addr = d;
                        st_data = s;
                        m_mem[d[7:0]] = s;
                end
                default: ; // undefined, nothing changes
                endcase
                if (alu && op != op_cmp && op != op_test)
                        m_reg[ins[7:4]] = r;
                if (alu && op != op_mvrr)
                        m_flags = '{c: cf, z: (r == '0), v: vf, s: r[15]};
        endtask

        // loads prog, resets the cpu and follows it instruction by instruction
        task automatic run_program(string name);
                int    len;
                int    exp_writes;
                int    errors_before;
                logic  st;
                logic  done;
                word_t st_addr;
                word_t st_data;
                word_t end_pc;

                errors_before = errors;
                exp_writes = 0;
                done = 1'b0;
                cycle_limit += 5 * prog.size();
                end_pc = 16'(prog.size() - 1); // final jr onto itself
                @(posedge clk);
                #1;
                reset = 1'b1;
                for (int i = 0; i < mem_words; i++) begin
                        mem[i] = (i < prog.size()) ? prog[i] : {~8'(i), 8'(i)};
                        m_mem[i] = mem[i];
                end
                m_reg = '{default: '0};
                m_flags = '0;
                m_pc = '0;
                repeat (5) begin
                        @(posedge clk);
                        #1;
                        compare_value("mem_wr", 16'd0, 16'(mem_wr));
                end
                n_writes = 0;
                reset = 1'b0;
                len = 2; // reset phase, then first address phase
                st = 1'b0;
                while (!done) begin
                        for (int k = 1; k <= len; k++) begin
                                @(posedge clk);
                                #1;
                                compare_value("mem_wr", 16'(st && k == 3), 16'(mem_wr));
                                if (st && k == 3) begin
                                        compare_value("mem_addr", st_addr, mem_addr);
                                        compare_value("mem_wdata", st_data, mem_wdata);
                                end
                        end
                        compare_value("fetch address", m_pc, mem_addr);
                        done = (m_pc == end_pc) || (errors != errors_before);
                        if (!done) begin
                                model_step(len, st, st_addr, st_data);
                                if (st)
                                        exp_writes++;
                        end
                end
                compare_value("write count", 16'(exp_writes), 16'(n_writes));
                tests++;
                if (errors == errors_before) begin
                        $display("test %s: pass", name);
                end else begin
                        tests_failed++;
                        $display("test %s: FAIL", name);
                end
        endtask

        initial begin
                word_t      v;
                logic [7:0] op;

                reset = 1'b1;
                for (int i = 0; i < mem_words; i++)
                        mem[i] = '0;

                prog.delete(); // short straight program after reset
                for (int r = 1; r < 4; r++)
                        load_reg(r, rnd_word());
                for (int i = 0; i < 4; i++)
                        put(alu_ops[pick(18)], pair(1 + pick(3), 1 + pick(3)));
                put(op_stc, 8'h00);
                put(op_clc, 8'h00);
                put(op_jr, 8'hFF);
                run_program("reset");

                prog.delete();
                for (int r = 1; r < reg_count; r++)
                        load_reg(r, rnd_word());
                for (int i = 0; i < 40; i++) begin
                        op = alu_ops[pick(18)];
                        if (op == op_adc || op == op_sbb)
                                put(pick(2) ? op_stc : op_clc, 8'h00);
                        put(op, pair(1 + pick(15), 1 + pick(15)));
                end
                load_reg(0, 16'h00C0); // r0 walks the store area
                for (int r = 1; r < reg_count; r++) begin
                        put(op_strr, pair(0, r));
                        put(op_inc, 8'h00);
                end
                put(op_jr, 8'hFF);
                run_program("alu");

                prog.delete();
                for (int i = 0; i < 18; i++) begin
                        v = rnd_word();
                        load_reg(1, v);
                        load_reg(2, (pick(4) == 0) ? v : rnd_word()); // equal now and then
                        put(pick(2) ? op_cmp : op_add, 8'h12);
                        put(cond_jumps[i % 6], 8'h01);
                        put_filler();
                end
                put(op_jr, 8'hFF);
                run_program("flags");

                prog.delete(); // data lives at 80..ff, above the program
                for (int i = 0; i < 6; i++) begin
                        load_reg(1, rnd_word() | 16'h0080);
                        load_reg(2, rnd_word());
                        put(op_strr, 8'h12);
                        put(op_ldrr, 8'h31);
                        load_reg(4, rnd_word() | 16'h0080);
                        put(op_ldrr, 8'h54);
                        load_reg(6, rnd_word() | 16'h0080);
                        put(op_strr, 8'h63);
                        put(op_strr, 8'h15);
                end
                put(op_jr, 8'hFF);
                run_program("memory");

                prog.delete();
                load_reg(1, rnd_word());
                load_reg(2, rnd_word());
                for (int i = 0; i < 6; i++) begin
                        put(op_jmpa, 8'h00);
                        prog.push_back(16'(prog.size() + 1 + pick(4))); // lands among fillers
                        for (int k = 0; k < 4; k++)
                                put_filler();
                        put(op_jr, 8'(pick(4)));
                        for (int k = 0; k < 3; k++)
                                put_filler();
                        put(op_jr, 8'h01); // forward, back one, forward
                        put(op_jr, 8'h01);
                        put(op_jr, 8'hFE);
                end
                load_reg(4, 16'h00F0);
                put(op_strr, 8'h41);
                put(op_inc, 8'h40);
                put(op_strr, 8'h42);
                put(op_jr, 8'hFF);
                run_program("jumps");

                $display("%0d tests, %0d failed, %0d checks, %0d mismatches", tests,
                        tests_failed, checks, errors);
                if (errors == 0)
                        $display("sim passed");
                else
                        $display("sim failed");
                $finish;
        end

endmodule
